// ==== verilog/pcie_macros.svh ====
`ifndef PCIE_MACROS_SVH
`define PCIE_MACROS_SVH

`define FLIT_WIDTH     512    // Bits per flit on the packet stream
`define FLIT_BYTES     (`FLIT_WIDTH / 8)

`define PDU_DEPTH      64     // Entries in each buffer
`define PDU_AWIDTH     6      // Width of the occupancy count

`define MAX_PKT_SIZE   8      // Largest packet in flits, sizes the room check

`define QUEUE_ID_WIDTH 8
`define EMPTY_WIDTH    6      // Unused bytes in the end flit
`define DESC_SIZE_WIDTH 16

`endif

// ==== verilog/pcie_pkg.sv ====
`include "pcie_macros.svh"

package pcie_pkg;

    // One flit as it sits in the packet buffer
    typedef struct packed {
        logic [`FLIT_WIDTH-1:0] data;    // Already byte-reversed
        logic                   sop;
        logic                   eop;
    } flit_lite_t;

    // One entry of the descriptor buffer, one per packet
    typedef struct packed {
        logic [`QUEUE_ID_WIDTH-1:0]  queue_id;
        logic [`DESC_SIZE_WIDTH-1:0] size;        // Packet length in flits
    } pkt_desc_t;

    // Per-packet metadata from the classifier side
    typedef struct packed {
        logic [`QUEUE_ID_WIDTH-1:0] queue_id;
    } metadata_t;

endpackage

// ==== verilog/fifo_if.sv ====
`timescale 1ns/100ps
`include "pcie_macros.svh"

interface fifo_if #(
    parameter type T = logic
);
    logic                   wr_en;
    T                       wr_data;
    logic [`PDU_AWIDTH-1:0] occup;       // Entries currently held
    T                       rd_data;     // Head entry, valid with rd_valid
    logic                   rd_valid;
    logic                   rd_ready;    // Pops the head when rd_valid is high

    modport writer (
        output wr_en,
        output wr_data,
        input  occup
    );

    modport buffer (
        input  wr_en,
        input  wr_data,
        input  rd_ready,
        output occup,
        output rd_data,
        output rd_valid
    );

    modport reader (
        output rd_ready,
        input  rd_data,
        input  rd_valid
    );
endinterface

// ==== verilog/sync_fifo.sv ====
`timescale 1ns/100ps
`include "pcie_macros.svh"

module sync_fifo #(
    parameter type T     = logic,
    parameter int  DEPTH = `PDU_DEPTH
) (
    input  logic   clk,
    input  logic   rst,
    fifo_if.buffer buf_if
);

    localparam int PW = $clog2(DEPTH);
    localparam logic [PW-1:0] LAST_PTR = PW'(DEPTH - 1);
    localparam logic [`PDU_AWIDTH-1:0] FULL_COUNT = `PDU_AWIDTH'(DEPTH - 1);

    T                       mem [DEPTH];
    logic [PW-1:0]          wr_ptr;
    logic [PW-1:0]          rd_ptr;
    logic [`PDU_AWIDTH-1:0] count;
    logic                   push;
    logic                   pop;
    logic                   full;

    assign push = buf_if.wr_en;
    assign pop  = buf_if.rd_valid && buf_if.rd_ready;
    assign full = (count == FULL_COUNT);    // One slot is kept free so count fits its width

    assign buf_if.rd_valid = (count != '0);
    assign buf_if.rd_data  = mem[rd_ptr];   // Show-ahead head entry
    assign buf_if.occup    = count;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= buf_if.wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // The writer's almost-full rule must keep it off a full buffer
    a_no_overflow: assert property (
        @(posedge clk) disable iff (rst)
        push |-> !full
    ) else $error("sync_fifo: write while full");

    // The reader only pops what it was shown
    a_no_underflow: assert property (
        @(posedge clk) disable iff (rst)
        buf_if.rd_ready |-> buf_if.rd_valid
    ) else $error("sync_fifo: pop while empty");

endmodule

// ==== verilog/pdu_gen.sv ====
`timescale 1ns/100ps
`include "pcie_macros.svh"

module pdu_gen
    import pcie_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`FLIT_WIDTH-1:0]  in_data,
    input  logic                    in_sop,
    input  logic                    in_eop,
    input  logic [`EMPTY_WIDTH-1:0] in_empty,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  logic                    in_meta_valid,
    input  metadata_t               in_meta_data,
    output logic                    in_meta_ready,
    fifo_if.writer                  pkt_wr,
    fifo_if.writer                  desc_wr
);

    typedef enum logic {
        IDLE,
        WRITE
    } state_t;

    // Room for a largest packet plus the two flits still in the pipeline
    localparam logic [`PDU_AWIDTH-1:0] PKT_LIMIT =
        `PDU_AWIDTH'(`PDU_DEPTH - 2 - `MAX_PKT_SIZE);
    localparam logic [`PDU_AWIDTH-1:0] DESC_LIMIT = `PDU_AWIDTH'(`PDU_DEPTH - 3);

    state_t                       state;
    logic                         accept;
    logic                         almost_full;
    logic [`DESC_SIZE_WIDTH-1:0]  flit_cnt;
    logic                         wren_r;
    logic                         sop_r;
    logic                         eop_r;
    logic [`FLIT_WIDTH-1:0]       data_r;
    logic [`FLIT_WIDTH-1:0]       data_swap;
    pkt_desc_t                    desc_r;

    assign in_ready    = (state == WRITE);
    assign accept      = in_valid && in_ready;
    assign almost_full = (pkt_wr.occup >= PKT_LIMIT) || (desc_wr.occup >= DESC_LIMIT);

    // Byte 0 of the flit ends up in the top byte
    always_comb begin
        for (int i = 0; i < `FLIT_BYTES; i++) begin
            data_swap[8*i +: 8] = data_r[`FLIT_WIDTH - 8*(i+1) +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= IDLE;
            flit_cnt      <= '0;
            wren_r        <= 1'b0;
            in_meta_ready <= 1'b0;
        end else begin
            wren_r        <= accept;
            in_meta_ready <= accept && in_eop;    // Releases the metadata of this packet
            case (state)
                IDLE: begin
                    flit_cnt <= '0;
                    // The metadata being released this cycle belongs to the last packet
                    if (in_meta_valid && !in_meta_ready && !almost_full) begin
                        state <= WRITE;
                    end
                end
                WRITE: begin
                    if (accept) begin
                        flit_cnt <= flit_cnt + 1'b1;
                        if (in_eop) begin
                            state <= IDLE;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            data_r <= in_data;
            sop_r  <= in_sop;
            eop_r  <= in_eop;
        end
        if (accept && in_eop) begin
            desc_r.queue_id <= in_meta_data.queue_id;
            desc_r.size     <= flit_cnt + 1'b1;    // Count includes the end flit
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pkt_wr.wr_en  <= 1'b0;
            desc_wr.wr_en <= 1'b0;
        end else begin
            pkt_wr.wr_en  <= wren_r;
            desc_wr.wr_en <= in_meta_ready;    // Lands with the end flit
        end
    end

    always_ff @(posedge clk) begin
        pkt_wr.wr_data  <= flit_lite_t'{data: data_swap, sop: sop_r, eop: eop_r};
        desc_wr.wr_data <= desc_r;
    end

    a_sop_first: assert property (
        @(posedge clk) disable iff (rst)
        accept |-> (in_sop == (flit_cnt == '0))
    ) else $error("pdu_gen: sop not on the first flit of a packet");

    a_empty_on_eop: assert property (
        @(posedge clk) disable iff (rst)
        (accept && !in_eop) |-> (in_empty == '0)
    ) else $error("pdu_gen: nonzero empty on a middle flit");

endmodule

// ==== verilog/pcie_tx.sv ====
`timescale 1ns/100ps
`include "pcie_macros.svh"

module pcie_tx
    import pcie_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    fifo_if.reader                     desc_rd,
    fifo_if.reader                     pkt_rd,
    output logic [`FLIT_WIDTH-1:0]     tx_data,
    output logic                       tx_sop,
    output logic                       tx_eop,
    output logic                       tx_valid,
    output logic [`QUEUE_ID_WIDTH-1:0] tx_queue_id,
    input  logic                       tx_ready
);

    pkt_desc_t                   cur_desc;
    pkt_desc_t                   desc_head;
    flit_lite_t                  flit_head;
    logic                        active;       // A descriptor is loaded
    logic [`DESC_SIZE_WIDTH-1:0] remaining;    // Flits left in the current packet
    logic                        last_flit;
    logic                        xfer;

    assign desc_head = desc_rd.rd_data;
    assign flit_head = pkt_rd.rd_data;

    assign last_flit = (remaining == `DESC_SIZE_WIDTH'(1));
    assign tx_valid  = active && pkt_rd.rd_valid;
    assign xfer      = tx_valid && tx_ready;

    assign tx_data     = flit_head.data;
    assign tx_sop      = flit_head.sop;
    assign tx_eop      = flit_head.eop;
    assign tx_queue_id = cur_desc.queue_id;

    assign pkt_rd.rd_ready  = xfer;
    assign desc_rd.rd_ready = xfer && last_flit;    // Descriptor leaves with its last flit

    always_ff @(posedge clk) begin
        if (rst) begin
            active    <= 1'b0;
            remaining <= '0;
        end else if (!active) begin
            if (desc_rd.rd_valid) begin
                active    <= 1'b1;
                remaining <= desc_head.size;
            end
        end else if (xfer) begin
            remaining <= remaining - 1'b1;
            if (last_flit) begin
                active <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!active && desc_rd.rd_valid) begin
            cur_desc <= desc_head;
        end
    end

    // Flit buffer and descriptor buffer must agree on where packets end
    a_eop_matches_size: assert property (
        @(posedge clk) disable iff (rst)
        tx_valid |-> (flit_head.eop == last_flit)
    ) else $error("pcie_tx: buffered eop disagrees with descriptor size");

endmodule

// ==== verilog/pcie_rx_top.sv ====
`timescale 1ns/100ps
`include "pcie_macros.svh"

module pcie_rx_top
    import pcie_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,

    input  logic [`FLIT_WIDTH-1:0]     in_data,
    input  logic                       in_sop,
    input  logic                       in_eop,
    input  logic [`EMPTY_WIDTH-1:0]    in_empty,
    input  logic                       in_valid,
    output logic                       in_ready,

    input  logic                       in_meta_valid,
    input  metadata_t                  in_meta_data,
    output logic                       in_meta_ready,

    output logic [`FLIT_WIDTH-1:0]     tx_data,
    output logic                       tx_sop,
    output logic                       tx_eop,
    output logic [`QUEUE_ID_WIDTH-1:0] tx_queue_id,
    output logic                       tx_valid,
    input  logic                       tx_ready
);

    fifo_if #(.T(flit_lite_t)) pkt_if ();
    fifo_if #(.T(pkt_desc_t))  desc_if ();

    pdu_gen u_pdu_gen (
        .clk           (clk),
        .rst           (rst),
        .in_data       (in_data),
        .in_sop        (in_sop),
        .in_eop        (in_eop),
        .in_empty      (in_empty),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_meta_valid (in_meta_valid),
        .in_meta_data  (in_meta_data),
        .in_meta_ready (in_meta_ready),
        .pkt_wr        (pkt_if.writer),
        .desc_wr       (desc_if.writer)
    );

    sync_fifo #(
        .T     (flit_lite_t),
        .DEPTH (`PDU_DEPTH)
    ) u_pkt_buf (
        .clk    (clk),
        .rst    (rst),
        .buf_if (pkt_if.buffer)
    );

    sync_fifo #(
        .T     (pkt_desc_t),
        .DEPTH (`PDU_DEPTH)
    ) u_desc_buf (
        .clk    (clk),
        .rst    (rst),
        .buf_if (desc_if.buffer)
    );

    pcie_tx u_pcie_tx (
        .clk         (clk),
        .rst         (rst),
        .desc_rd     (desc_if.reader),
        .pkt_rd      (pkt_if.reader),
        .tx_data     (tx_data),
        .tx_sop      (tx_sop),
        .tx_eop      (tx_eop),
        .tx_valid    (tx_valid),
        .tx_queue_id (tx_queue_id),
        .tx_ready    (tx_ready)
    );

endmodule

// ==== verif/tb_pcie_rx.sv ====
`timescale 1ns/100ps
`include "pcie_macros.svh"

module tb_pcie_rx
    import pcie_pkg::*;
();

    localparam int NUM_ROWS     = 15;
    localparam int STALL_CYCLES = 40;    // Input wait that counts as a back-pressure block

    typedef struct packed {
        int                         flits;
        logic [`QUEUE_ID_WIDTH-1:0] qid;
        logic [`EMPTY_WIDTH-1:0]    empty;    // Only on the end flit
        logic [31:0]                seed;
        logic                       bp;       // Hold tx_ready low while this packet is offered
    } row_t;

    typedef struct packed {
        logic [`FLIT_WIDTH-1:0]     data;
        logic                       sop;
        logic                       eop;
        logic [`QUEUE_ID_WIDTH-1:0] qid;
        int                         row;
    } exp_t;

    localparam row_t ROWS [NUM_ROWS] = '{
        '{1, 8'h11, 6'd5,  32'h0000_0001, 1'b0},
        '{2, 8'h22, 6'd0,  32'h1234_5678, 1'b0},
        '{3, 8'h33, 6'd12, 32'h0f0f_0f0f, 1'b0},
        '{5, 8'h44, 6'd63, 32'hdead_beef, 1'b0},
        '{8, 8'h55, 6'd1,  32'h5a5a_a5a5, 1'b0},
        '{8, 8'h60, 6'd0,  32'h0000_0060, 1'b1},
        '{8, 8'h61, 6'd7,  32'h0000_0061, 1'b1},
        '{8, 8'h62, 6'd0,  32'h0000_0062, 1'b1},
        '{8, 8'h63, 6'd9,  32'h0000_0063, 1'b1},
        '{8, 8'h64, 6'd0,  32'h0000_0064, 1'b1},
        '{8, 8'h65, 6'd2,  32'h0000_0065, 1'b1},
        '{8, 8'h66, 6'd0,  32'h0000_0066, 1'b1},
        '{8, 8'h67, 6'd4,  32'h0000_0067, 1'b1},
        '{4, 8'h77, 6'd0,  32'hcafe_f00d, 1'b0},
        '{7, 8'h88, 6'd3,  32'h8888_0000, 1'b0}
    };

    logic                       clk;
    logic                       rst;
    logic [`FLIT_WIDTH-1:0]     in_data;
    logic                       in_sop;
    logic                       in_eop;
    logic [`EMPTY_WIDTH-1:0]    in_empty;
    logic                       in_valid;
    logic                       in_ready;
    logic                       in_meta_valid;
    metadata_t                  in_meta_data;
    logic                       in_meta_ready;
    logic [`FLIT_WIDTH-1:0]     tx_data;
    logic                       tx_sop;
    logic                       tx_eop;
    logic [`QUEUE_ID_WIDTH-1:0] tx_queue_id;
    logic                       tx_valid;
    logic                       tx_ready;

    integer seed       = 32'h7d63e8f0;
    integer ready_seed = 32'h7d63e8f0;
    logic   hold_tx    = 1'b0;
    exp_t   exp_q [$];
    int     pkt_err [NUM_ROWS];
    int     errors      = 0;
    int     pass_cnt    = 0;
    int     fail_cnt    = 0;
    int     in_flits    = 0;
    int     out_flits   = 0;
    int     out_pkts    = 0;
    int     meta_pulses = 0;
    int     stalls      = 0;
    int     cycle_cnt;
    int     limit;

    pcie_rx_top DUT (
        .clk           (clk),
        .rst           (rst),
        .in_data       (in_data),
        .in_sop        (in_sop),
        .in_eop        (in_eop),
        .in_empty      (in_empty),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_meta_valid (in_meta_valid),
        .in_meta_data  (in_meta_data),
        .in_meta_ready (in_meta_ready),
        .tx_data       (tx_data),
        .tx_sop        (tx_sop),
        .tx_eop        (tx_eop),
        .tx_queue_id   (tx_queue_id),
        .tx_valid      (tx_valid),
        .tx_ready      (tx_ready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Output byte 63-b carries input byte b
    function automatic logic [`FLIT_WIDTH-1:0] reverse_bytes(input logic [`FLIT_WIDTH-1:0] d);
        logic [`FLIT_WIDTH-1:0] r;
        for (int b = 0; b < `FLIT_WIDTH / 8; b++) begin
            r[`FLIT_WIDTH-1-8*b -: 8] = d[8*b +: 8];
        end
        return r;
    endfunction

    task automatic report_mismatch(input string name, input logic [`FLIT_WIDTH-1:0] expected,
                                   input logic [`FLIT_WIDTH-1:0] actual, input int row);
        errors++;
        if (row >= 0) begin
            pkt_err[row]++;
        end
        $display("[FAIL] %0t %s expected %0h got %0h", $time, name, expected, actual);
    endtask

    task automatic check_idle_outputs();
        if (in_ready !== 1'b0) begin
            report_mismatch("in_ready", '0, `FLIT_WIDTH'(in_ready), -1);
        end
        if (in_meta_ready !== 1'b0) begin
            report_mismatch("in_meta_ready", '0, `FLIT_WIDTH'(in_meta_ready), -1);
        end
        if (tx_valid !== 1'b0) begin
            report_mismatch("tx_valid", '0, `FLIT_WIDTH'(tx_valid), -1);
        end
    endtask

    // Drives flit f of row r and queues what should come out for it
    task automatic present_flit(input int r, input int f);
        logic [`FLIT_WIDTH-1:0] d;
        exp_t                   e;
        for (int w = 0; w < `FLIT_WIDTH / 32; w++) begin
            d[32*w +: 32] = $random(seed) ^ ROWS[r].seed;
        end
        in_data  = d;
        in_sop   = (f == 0);
        in_eop   = (f == ROWS[r].flits - 1);
        in_empty = (f == ROWS[r].flits - 1) ? ROWS[r].empty : '0;
        in_valid = 1'b1;
        e.data   = reverse_bytes(d);
        e.sop    = (f == 0);
        e.eop    = (f == ROWS[r].flits - 1);
        e.qid    = ROWS[r].qid;
        e.row    = r;
        exp_q.push_back(e);
        in_flits++;
    endtask

    task automatic send_packet(input int r);
        int waited;
        if (ROWS[r].bp) begin
            hold_tx = 1'b1;
        end
        present_flit(r, 0);
        in_meta_valid = 1'b0;
        repeat (3) begin    // Data is offered before its metadata
            @(posedge clk);
            #10;
            if (in_ready !== 1'b0) begin
                report_mismatch("in_ready", '0, `FLIT_WIDTH'(in_ready), r);
            end
        end
        in_meta_valid         = 1'b1;
        in_meta_data.queue_id = ROWS[r].qid;
        for (int f = 0; f < ROWS[r].flits; f++) begin
            if (f > 0) begin
                present_flit(r, f);
            end
            waited = 0;
            while (in_ready !== 1'b1) begin
                @(posedge clk);
                #10;
                waited++;
                if (hold_tx && waited == STALL_CYCLES) begin
                    hold_tx = 1'b0;
                    stalls++;
                    $display("%0t: in_ready low for %0d cycles, releasing tx_ready",
                             $time, STALL_CYCLES);
                end
            end
            @(posedge clk);    // The flit is taken on this edge
            #10;
        end
        if (in_meta_ready !== 1'b1) begin
            report_mismatch("in_meta_ready", `FLIT_WIDTH'(1'b1), `FLIT_WIDTH'(in_meta_ready), r);
        end
        in_meta_valid = 1'b0;
        in_valid      = 1'b0;
    endtask

    task automatic check_output();
        exp_t e;
        if (exp_q.size() == 0) begin
            errors++;
            $display("%0t: output flit for queue %0h arrived with no flit expected", $time,
                     tx_queue_id);
        end else begin
            e = exp_q.pop_front();
            if (tx_data !== e.data) begin
                report_mismatch("tx_data", e.data, tx_data, e.row);
            end
            if (tx_sop !== e.sop) begin
                report_mismatch("tx_sop", `FLIT_WIDTH'(e.sop), `FLIT_WIDTH'(tx_sop), e.row);
            end
            if (tx_eop !== e.eop) begin
                report_mismatch("tx_eop", `FLIT_WIDTH'(e.eop), `FLIT_WIDTH'(tx_eop), e.row);
            end
            if (tx_queue_id !== e.qid) begin
                report_mismatch("tx_queue_id", `FLIT_WIDTH'(e.qid), `FLIT_WIDTH'(tx_queue_id),
                                e.row);
            end
            out_flits++;
            if (e.eop) begin
                out_pkts++;
                if (pkt_err[e.row] == 0) begin
                    pass_cnt++;
                    $display("test packet %0d (queue %0h, %0d flits): pass", e.row, e.qid,
                             ROWS[e.row].flits);
                end else begin
                    fail_cnt++;
                    $display("test packet %0d (queue %0h): fail with %0d errors", e.row, e.qid,
                             pkt_err[e.row]);
                end
            end
        end
    endtask

    // All DUT outputs and tx_ready are settled at the falling edge
    always @(negedge clk) begin
        if (!rst && tx_valid && tx_ready) begin
            check_output();
        end
        if (!rst && in_meta_ready) begin
            meta_pulses++;
        end
    end

    initial begin
        logic hold_now;
        tx_ready = 1'b0;
        forever begin
            @(posedge clk);
            hold_now = hold_tx;    // Taken at the edge where hold_tx is stable
            #10;
            tx_ready = hold_now ? 1'b0 : (($random(ready_seed) & 3) != 0);
        end
    end

    initial begin
        limit = 200;
        for (int r = 0; r < NUM_ROWS; r++) begin
            limit += 20 * (ROWS[r].flits + 4);
        end
        cycle_cnt = 0;
        while (cycle_cnt < limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout after %0d cycles, %0d of %0d packets came out", cycle_cnt, out_pkts,
                 NUM_ROWS);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        rst           = 1'b1;
        in_data       = '0;
        in_sop        = 1'b0;
        in_eop        = 1'b0;
        in_empty      = '0;
        in_valid      = 1'b0;
        in_meta_valid = 1'b0;
        in_meta_data  = '0;
        for (int c = 0; c < 10; c++) begin
            @(posedge clk);
            #10;
            check_idle_outputs();
        end
        rst = 1'b0;
        @(posedge clk);
        #10;
        check_idle_outputs();
        if (errors == 0) begin
            pass_cnt++;
            $display("test reset: pass");
        end else begin
            fail_cnt++;
            $display("test reset: fail");
        end

        for (int r = 0; r < NUM_ROWS; r++) begin
            send_packet(r);
        end
        wait (out_pkts == NUM_ROWS);
        @(posedge clk);
        #10;

        if (meta_pulses != NUM_ROWS) begin
            errors++;
            $display("in_meta_ready pulsed %0d times for %0d packets", meta_pulses, NUM_ROWS);
        end
        if (stalls > 0 && out_flits == in_flits && exp_q.size() == 0) begin
            pass_cnt++;
            $display("test back-pressure: pass, %0d flits in and out", out_flits);
        end else begin
            fail_cnt++;
            $display("test back-pressure: fail, %0d stalls seen, %0d flits in, %0d flits out",
                     stalls, in_flits, out_flits);
        end

        $display("Tests: %0d passed, %0d failed, %0d errors", pass_cnt, fail_cnt, errors);
        if (errors == 0 && fail_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+verilog
verilog/pcie_pkg.sv
verilog/fifo_if.sv
verilog/sync_fifo.sv
verilog/pdu_gen.sv
verilog/pcie_tx.sv
verilog/pcie_rx_top.sv
verif/tb_pcie_rx.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f vlog.f --top-module tb_pcie_rx -Mdir obj_dir
	./obj_dir/Vtb_pcie_rx > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	cat $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
